// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_sub,
        op_addi,
        op_ld,
        op_st
    } op_e;

    localparam word_t reset_pc = 32'h1c000000;
    localparam word_t pc_step = 32'd4;

    // register number fields
    localparam int rd_lsb = 0;
    localparam int rj_lsb = 5;
    localparam int rk_lsb = 10;

    // si12 immediate
    localparam int imm_lsb = 10;
    localparam int imm_width = 12;

    // 3r ops match instr[31:15], 2ri12 ops match instr[31:22]
    localparam int op_3r_lsb = 15;
    localparam int op_2ri12_lsb = 22;
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_ld_w = 10'h0a2;
    localparam logic [9:0] opc_st_w = 10'h0a6;

    localparam logic [1:0] word_size = 2'd2;
    localparam logic [3:0] full_strobe = 4'b1111;

endpackage

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic       req;
        logic       wr;
        logic [1:0] size;
        word_t      addr;
        logic [3:0] wstrb;
        word_t      wdata;
    } sram_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } sram_rsp_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } id_payload_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        word_t    rj_val;
        word_t    rk_val;
        word_t    imm;
        word_t    pc;
    } ex_payload_t;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        word_t    alu_res;
        word_t    pc;
    } mem_payload_t;

    // result is the alu value or the loaded word
    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        word_t    result;
        word_t    pc;
    } wb_payload_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [3:0] rf_wen;
        reg_idx_t   rf_wnum;
        word_t      rf_wdata;
    } trace_t;

    function automatic logic writes_reg(op_e op);
        return op inside {op_add, op_sub, op_addi, op_ld};
    endfunction

endpackage

`default_nettype wire

// File: hw/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst_n,
    input  logic     valid_in,
    input  payload_t data_in,
    input  logic     ready_go,
    input  logic     allow_in,
    output logic     allow_out,
    output logic     valid_out,
    output payload_t data_out
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held item leaves this cycle
    assign allow_out = !valid_q || (ready_go && allow_in);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (allow_out) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge aclk) begin
        if (allow_out && valid_in) begin
            data_q <= data_in;
        end
    end

    assign valid_out = valid_q;
    assign data_out = data_q;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file (
    input  logic        aclk,
    input  logic        rst_n,
    input  logic [4:0]  rj,
    input  logic [4:0]  rk,
    output logic [31:0] rj_val,
    output logic [31:0] rk_val,
    input  logic [4:0]  wnum,
    input  logic        wen,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];
    logic        wr_live;

    // r0 is never written so it keeps its reset zero
    assign wr_live = wen && (wnum != 5'd0);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wnum] <= wdata;
        end
    end

    // same-cycle write shows through
    assign rj_val = (wr_live && wnum == rj) ? wdata : regs[rj];
    assign rk_val = (wr_live && wnum == rk) ? wdata : regs[rk];

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`default_nettype none

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    output sram_req_t inst_req,
    input  sram_rsp_t inst_rsp,
    input  word_t     stage_pc,
    input  logic      stage_allow,
    output logic      issue_valid,
    output word_t     issue_pc,
    output logic      fetch_ready,
    output word_t     instr
);

    logic  running;
    logic  started;
    logic  buf_valid;
    word_t buf_instr;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            started <= 1'b0;
        end else begin
            running <= 1'b1;
            if (issue_valid) begin
                started <= 1'b1;
            end
        end
    end

    // if_stage keeps the last accepted pc even after it drains
    assign issue_pc = started ? stage_pc + pc_step : reset_pc;

    assign inst_req.req = running && stage_allow;
    assign inst_req.wr = 1'b0;
    assign inst_req.size = word_size;
    assign inst_req.addr = issue_pc;
    assign inst_req.wstrb = full_strobe;
    assign inst_req.wdata = '0;

    assign issue_valid = inst_req.req && inst_rsp.addr_ok;

    // park the word while decode is stalled
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (inst_rsp.data_ok && !stage_allow) begin
            buf_valid <= 1'b1;
        end else if (stage_allow) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_rsp.data_ok && !stage_allow) begin
            buf_instr <= inst_rsp.rdata;
        end
    end

    // only the item held in if_stage can have data back
    assign fetch_ready = inst_rsp.data_ok || buf_valid;
    assign instr = buf_valid ? buf_instr : inst_rsp.rdata;

    a_req_held: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_req.req && !inst_rsp.addr_ok |=> inst_req.req && $stable(inst_req.addr));

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`default_nettype none

module decode_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,
    input  id_payload_t instr_in,
    input  logic        id_valid,
    input  reg_idx_t    ex_rd,
    input  logic        ex_wr,
    input  reg_idx_t    mem_rd,
    input  logic        mem_wr,
    input  reg_idx_t    rf_wnum,
    input  logic        rf_wen,
    input  word_t       rf_wdata,
    output logic        decode_ready,
    output ex_payload_t ex_out
);

    word_t    instr;
    op_e      op;
    reg_idx_t rd_idx;
    reg_idx_t rj_idx;
    reg_idx_t src2_idx;
    word_t    imm;
    word_t    rj_val;
    word_t    src2_val;
    logic     reads_src2;
    logic     rj_hazard;
    logic     src2_hazard;

    assign instr = instr_in.instr;

    always_comb begin
        if (instr[31:op_3r_lsb] == opc_add_w) begin
            op = op_add;
        end else if (instr[31:op_3r_lsb] == opc_sub_w) begin
            op = op_sub;
        end else if (instr[31:op_2ri12_lsb] == opc_addi_w) begin
            op = op_addi;
        end else if (instr[31:op_2ri12_lsb] == opc_ld_w) begin
            op = op_ld;
        end else if (instr[31:op_2ri12_lsb] == opc_st_w) begin
            op = op_st;
        end else begin
            op = op_nop;
        end
    end

    assign rd_idx = instr[rd_lsb +: $bits(reg_idx_t)];
    assign rj_idx = instr[rj_lsb +: $bits(reg_idx_t)];
    // st.w reads its store data from rd
    assign src2_idx = (op == op_st) ? rd_idx : instr[rk_lsb +: $bits(reg_idx_t)];
    assign imm = {{($bits(word_t) - imm_width){instr[imm_lsb + imm_width - 1]}},
                  instr[imm_lsb +: imm_width]};

    reg_file i_rf (
        .aclk(aclk), .rst_n(rst_n),
        .rj(rj_idx),
        .rk(src2_idx),
        .rj_val(rj_val),
        .rk_val(src2_val),
        .wnum(rf_wnum),
        .wen(rf_wen),
        .wdata(rf_wdata)
    );

    // ex_rd and mem_rd are zero for ops that do not write
    assign reads_src2 = (op == op_add) || (op == op_sub) || (op == op_st);
    assign rj_hazard = (op != op_nop) && (rj_idx != '0)
                       && ((ex_wr && ex_rd == rj_idx) || (mem_wr && mem_rd == rj_idx));
    assign src2_hazard = reads_src2 && (src2_idx != '0)
                         && ((ex_wr && ex_rd == src2_idx) || (mem_wr && mem_rd == src2_idx));

    assign decode_ready = id_valid && !rj_hazard && !src2_hazard;

    assign ex_out = '{
        op:     op,
        rd:     writes_reg(op) ? rd_idx : '0,
        rj_val: rj_val,
        rk_val: src2_val,
        imm:    imm,
        pc:     instr_in.pc
    };

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`default_nettype none

module exec_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  ex_payload_t  ex_in,
    input  logic         ex_valid,
    input  logic         mem_allow,
    output sram_req_t    data_req,
    input  logic         data_rsp_addr_ok,
    output logic         exec_ready,
    output mem_payload_t mem_out
);

    word_t src2;
    word_t alu_res;
    logic  is_mem;

    assign src2 = (ex_in.op == op_add || ex_in.op == op_sub) ? ex_in.rk_val : ex_in.imm;
    assign alu_res = (ex_in.op == op_sub) ? ex_in.rj_val - src2 : ex_in.rj_val + src2;

    assign is_mem = ex_in.op inside {op_ld, op_st};

    // issue only when mem_stage can take the item on acceptance
    assign data_req.req = ex_valid && is_mem && mem_allow;
    assign data_req.wr = (ex_in.op == op_st);
    assign data_req.size = word_size;
    assign data_req.addr = alu_res;
    assign data_req.wstrb = full_strobe;
    assign data_req.wdata = ex_in.rk_val;

    assign exec_ready = ex_valid && (!is_mem || (data_req.req && data_rsp_addr_ok));

    assign mem_out = '{
        op:      ex_in.op,
        rd:      ex_in.rd,
        alu_res: alu_res,
        pc:      ex_in.pc
    };

endmodule

`default_nettype wire

// File: hw/writeback_unit.sv
`default_nettype none

module writeback_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic         aclk,
    input  logic         rst_n,
    input  mem_payload_t mem_in,
    input  logic         mem_valid,
    input  logic         data_ok,
    input  word_t        rdata,
    output logic         mem_ready,
    output logic         rf_wen,
    output reg_idx_t     rf_wnum,
    output word_t        rf_wdata,
    output trace_t       trace
);

    logic        mem_is_mem;
    logic        buf_valid;
    word_t       buf_data;
    word_t       ld_data;
    logic        wb_valid;
    wb_payload_t wb_q;

    assign mem_is_mem = mem_in.op inside {op_ld, op_st};
    assign mem_ready = mem_valid && (!mem_is_mem || data_ok || buf_valid);

    // data back before its item is seen here
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (data_ok && !mem_ready) begin
            buf_valid <= 1'b1;
        end else if (mem_ready) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (data_ok && !mem_ready) begin
            buf_data <= rdata;
        end
    end

    assign ld_data = buf_valid ? buf_data : rdata;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_ready;
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_ready) begin
            wb_q <= '{
                op:     mem_in.op,
                rd:     mem_in.rd,
                result: (mem_in.op == op_ld) ? ld_data : mem_in.alu_res,
                pc:     mem_in.pc
            };
        end
    end

    assign rf_wen = wb_valid && writes_reg(wb_q.op) && (wb_q.rd != '0);
    assign rf_wnum = wb_q.rd;
    assign rf_wdata = wb_q.result;

    assign trace = '{
        valid:    wb_valid,
        pc:       wb_q.pc,
        rf_wen:   rf_wen ? full_strobe : 4'b0000,
        rf_wnum:  wb_q.rd,
        rf_wdata: wb_q.result
    };

    a_data_ok_expected: assert property (@(posedge aclk) disable iff (!rst_n)
        data_ok |-> mem_valid && mem_is_mem && !buf_valid);

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
`default_nettype none

module cpu_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    output sram_req_t inst_req,
    input  sram_rsp_t inst_rsp,
    output sram_req_t data_req,
    input  sram_rsp_t data_rsp,
    output trace_t    trace
);

    logic         fetch_issue;
    word_t        fetch_pc;
    logic         fetch_ready;
    word_t        fetch_instr;
    logic         if_allow;
    word_t        if_pc;
    id_payload_t  id_in;
    logic         id_allow;
    logic         id_valid;
    id_payload_t  id_q;
    logic         decode_ready;
    ex_payload_t  ex_in;
    logic         ex_allow;
    logic         ex_valid;
    ex_payload_t  ex_q;
    logic         exec_ready;
    mem_payload_t mem_in;
    logic         mem_allow;
    logic         mem_valid;
    mem_payload_t mem_q;
    logic         mem_ready;
    logic         rf_wen;
    reg_idx_t     rf_wnum;
    word_t        rf_wdata;

    fetch_unit i_fetch (
        .aclk(aclk), .rst_n(rst_n),
        .inst_req(inst_req),
        .inst_rsp(inst_rsp),
        .stage_pc(if_pc),
        .stage_allow(if_allow),
        .issue_valid(fetch_issue),
        .issue_pc(fetch_pc),
        .fetch_ready(fetch_ready),
        .instr(fetch_instr)
    );

    // fetch_ready is only high for the item held in if_stage
    pipe_stage #(.payload_t(word_t)) if_stage (
        .aclk(aclk), .rst_n(rst_n),
        .valid_in(fetch_issue),
        .data_in(fetch_pc),
        .ready_go(fetch_ready),
        .allow_in(id_allow),
        .allow_out(if_allow),
        .valid_out(),
        .data_out(if_pc)
    );

    assign id_in = '{pc: if_pc, instr: fetch_instr};

    pipe_stage #(.payload_t(id_payload_t)) id_stage (
        .aclk(aclk), .rst_n(rst_n),
        .valid_in(fetch_ready),
        .data_in(id_in),
        .ready_go(decode_ready),
        .allow_in(ex_allow),
        .allow_out(id_allow),
        .valid_out(id_valid),
        .data_out(id_q)
    );

    decode_unit i_decode (
        .aclk(aclk), .rst_n(rst_n),
        .instr_in(id_q),
        .id_valid(id_valid),
        .ex_rd(ex_q.rd),
        .ex_wr(ex_valid),
        .mem_rd(mem_q.rd),
        .mem_wr(mem_valid),
        .rf_wnum(rf_wnum),
        .rf_wen(rf_wen),
        .rf_wdata(rf_wdata),
        .decode_ready(decode_ready),
        .ex_out(ex_in)
    );

    pipe_stage #(.payload_t(ex_payload_t)) ex_stage (
        .aclk(aclk), .rst_n(rst_n),
        .valid_in(decode_ready),
        .data_in(ex_in),
        .ready_go(exec_ready),
        .allow_in(mem_allow),
        .allow_out(ex_allow),
        .valid_out(ex_valid),
        .data_out(ex_q)
    );

    exec_unit i_exec (
        .ex_in(ex_q),
        .ex_valid(ex_valid),
        .mem_allow(mem_allow),
        .data_req(data_req),
        .data_rsp_addr_ok(data_rsp.addr_ok),
        .exec_ready(exec_ready),
        .mem_out(mem_in)
    );

    // writeback takes an item every cycle
    pipe_stage #(.payload_t(mem_payload_t)) mem_stage (
        .aclk(aclk), .rst_n(rst_n),
        .valid_in(exec_ready),
        .data_in(mem_in),
        .ready_go(mem_ready),
        .allow_in(1'b1),
        .allow_out(mem_allow),
        .valid_out(mem_valid),
        .data_out(mem_q)
    );

    writeback_unit i_writeback (
        .aclk(aclk), .rst_n(rst_n),
        .mem_in(mem_q),
        .mem_valid(mem_valid),
        .data_ok(data_rsp.data_ok),
        .rdata(data_rsp.rdata),
        .mem_ready(mem_ready),
        .rf_wen(rf_wen),
        .rf_wnum(rf_wnum),
        .rf_wdata(rf_wdata),
        .trace(trace)
    );

endmodule

`default_nettype wire

// File: verification/sram_model.sv
`default_nettype none

module sram_model
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      waits,
    input  sram_req_t req,
    output sram_rsp_t rsp
);

    localparam int depth = 256;
    localparam logic [7:0] lfsr_seed = 8'd76;

    word_t      mem [depth];
    word_t      pending [$];
    logic [7:0] lfsr;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // accept with the values seen just before the edge
    always @(posedge aclk) begin
        if (rst_n && req.req && rsp.addr_ok) begin
            if (req.wr) begin
                mem[req.addr[9:2]] = req.wdata;
                pending.push_back('0);
            end else begin
                pending.push_back(mem[req.addr[9:2]]);
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge aclk) begin
        if (!rst_n) begin
            pending.delete();
            lfsr = lfsr_seed;
            rsp <= '0;
        end else begin
            if (waits) begin
                lfsr = lfsr_step(lfsr);
                rsp.addr_ok <= lfsr[0];
            end else begin
                rsp.addr_ok <= 1'b1;
            end
            rsp.data_ok <= 1'b0;
            if (pending.size() > 0) begin
                if (waits) begin
                    lfsr = lfsr_step(lfsr);
                end
                if (!waits || lfsr[0]) begin
                    rsp.data_ok <= 1'b1;
                    rsp.rdata <= pending.pop_front();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int max_instr = 32;
    // four programs of 7, 6, 6 and 6 instructions, each run twice
    localparam int timeout_cycles = 2 * (20 * (7 + 6 + 6 + 6) + 50 * 4);

    logic      aclk;
    logic      rst_n;
    logic      wait_en;
    sram_req_t inst_req;
    sram_rsp_t inst_rsp;
    sram_req_t data_req;
    sram_rsp_t data_rsp;
    trace_t    trace;

    int cycle_count;
    int word_errs;
    int reg_errs;
    int valid_errs;
    int n_checks;

    int          n_instr;
    op_e         prog_op [max_instr];
    reg_idx_t    prog_rd [max_instr];
    reg_idx_t    prog_rj [max_instr];
    reg_idx_t    prog_rk [max_instr];
    logic [11:0] prog_imm [max_instr];
    word_t       prog_word [max_instr];
    logic [3:0]  exp_wen [max_instr];
    reg_idx_t    exp_wnum [max_instr];
    word_t       exp_wdata [max_instr];

    cpu_core i_dut (
        .aclk(aclk), .rst_n(rst_n),
        .inst_req(inst_req), .inst_rsp(inst_rsp),
        .data_req(data_req), .data_rsp(data_rsp),
        .trace(trace)
    );

    sram_model i_imem (
        .aclk(aclk), .rst_n(rst_n), .waits(wait_en),
        .req(inst_req), .rsp(inst_rsp)
    );

    sram_model i_dmem (
        .aclk(aclk), .rst_n(rst_n), .waits(wait_en),
        .req(data_req), .rsp(data_rsp)
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: no progress after %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_word(string name, word_t exp, word_t act);
        n_checks++;
        if (exp !== act) begin
            word_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t exp, reg_idx_t act);
        n_checks++;
        if (exp !== act) begin
            reg_errs++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_trace_valid(string name, logic exp, logic act);
        n_checks++;
        if (exp !== act) begin
            valid_errs++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic word_t imem_fill(int idx);
        return 32'hffc00000 | (idx << 2);
    endfunction

    function automatic word_t dmem_fill(int idx);
        return (idx << 2) ^ 32'hc3a50000;
    endfunction

    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic emit(op_e op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk, logic [11:0] imm);
        prog_op[n_instr] = op;
        prog_rd[n_instr] = rd;
        prog_rj[n_instr] = rj;
        prog_rk[n_instr] = rk;
        prog_imm[n_instr] = imm;
        case (op)
            op_add:  prog_word[n_instr] = {17'h00020, rk, rj, rd};
            op_sub:  prog_word[n_instr] = {17'h00022, rk, rj, rd};
            op_addi: prog_word[n_instr] = {10'h00a, imm, rj, rd};
            op_ld:   prog_word[n_instr] = {10'h0a2, imm, rj, rd};
            default: prog_word[n_instr] = {10'h0a6, imm, rj, rd};
        endcase
        n_instr++;
    endtask

    // an encoding outside the decoded set
    task automatic emit_raw(word_t w);
        prog_op[n_instr] = op_nop;
        prog_rd[n_instr] = '0;
        prog_word[n_instr] = w;
        n_instr++;
    endtask

    // expected register writes from the instruction rules
    task automatic run_reference();
        word_t ref_regs [32];
        word_t ref_mem [256];
        word_t a;
        word_t res;
        logic  wr;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = dmem_fill(i);
        end
        for (int i = 0; i < n_instr; i++) begin
            a = ref_regs[prog_rj[i]];
            res = '0;
            case (prog_op[i])
                op_add:  res = a + ref_regs[prog_rk[i]];
                op_sub:  res = a - ref_regs[prog_rk[i]];
                op_addi: res = a + sext12(prog_imm[i]);
                op_ld: begin
                    res = a + sext12(prog_imm[i]);
                    res = ref_mem[res[9:2]];
                end
                op_st: begin
                    res = a + sext12(prog_imm[i]);
                    ref_mem[res[9:2]] = ref_regs[prog_rd[i]];
                end
                default: res = '0;
            endcase
            wr = prog_op[i] inside {op_add, op_sub, op_addi, op_ld};
            exp_wnum[i] = prog_rd[i];
            exp_wen[i] = (wr && prog_rd[i] != '0) ? 4'hf : 4'h0;
            exp_wdata[i] = res;
            if (exp_wen[i] != 4'h0) begin
                ref_regs[prog_rd[i]] = res;
            end
        end
    endtask

    task automatic pulse_reset(string name);
        @(negedge aclk);
        rst_n <= 1'b0;
        repeat (10) @(negedge aclk);
        check_word({name, " reset inst req"}, 32'd0, {31'd0, inst_req.req});
        check_word({name, " reset data req"}, 32'd0, {31'd0, data_req.req});
        check_trace_valid({name, " reset trace"}, 1'b0, trace.valid);
        rst_n <= 1'b1;
        #10;
        check_word({name, " first inst req"}, 32'd0, {31'd0, inst_req.req});
        check_word({name, " first data req"}, 32'd0, {31'd0, data_req.req});
        check_trace_valid({name, " first trace"}, 1'b0, trace.valid);
    endtask

    task automatic run_program(string name, logic waits_on, logic back_to_back);
        int got;
        int prev_cycle;
        for (int i = 0; i < 256; i++) begin
            i_imem.mem[i] = imem_fill(i);
            i_dmem.mem[i] = dmem_fill(i);
        end
        for (int i = 0; i < n_instr; i++) begin
            i_imem.mem[reset_pc[9:2] + i] = prog_word[i];
        end
        run_reference();
        wait_en <= waits_on;
        pulse_reset(name);
        got = 0;
        prev_cycle = 0;
        while (got < n_instr) begin
            @(negedge aclk);
            if (trace.valid) begin
                check_word({name, " pc"}, reset_pc + got * pc_step, trace.pc);
                check_word({name, " wen"}, {28'd0, exp_wen[got]}, {28'd0, trace.rf_wen});
                if (exp_wen[got] != 4'h0) begin
                    check_reg({name, " wnum"}, exp_wnum[got], trace.rf_wnum);
                    check_word({name, " wdata"}, exp_wdata[got], trace.rf_wdata);
                end
                if (back_to_back && got > 0) begin
                    check_word({name, " retire gap"}, 32'd1, cycle_count - prev_cycle);
                end
                prev_cycle = cycle_count;
                got++;
            end
        end
    endtask

    task automatic build_independent();
        n_instr = 0;
        emit(op_addi, 5'd1, 5'd0, 5'd0, 12'h123);
        emit(op_addi, 5'd2, 5'd0, 5'd0, 12'hff9);
        emit(op_addi, 5'd3, 5'd0, 5'd0, 12'h7ff);
        emit(op_addi, 5'd5, 5'd0, 5'd0, 12'h800);
        emit(op_add, 5'd4, 5'd1, 5'd2, 12'h000);
        emit(op_sub, 5'd6, 5'd3, 5'd1, 12'h000);
        emit(op_addi, 5'd7, 5'd1, 5'd0, 12'h001);
    endtask

    task automatic build_chain();
        n_instr = 0;
        emit(op_addi, 5'd1, 5'd0, 5'd0, 12'h003);
        emit(op_add, 5'd2, 5'd1, 5'd1, 12'h000);
        emit(op_sub, 5'd3, 5'd2, 5'd1, 12'h000);
        emit(op_add, 5'd4, 5'd3, 5'd3, 12'h000);
        emit(op_addi, 5'd4, 5'd4, 5'd0, 12'hfff);
        emit(op_sub, 5'd5, 5'd4, 5'd2, 12'h000);
    endtask

    // st.w takes its data from rd
    task automatic build_mem();
        n_instr = 0;
        emit(op_addi, 5'd10, 5'd0, 5'd0, 12'h040);
        emit(op_addi, 5'd11, 5'd0, 5'd0, 12'h5a5);
        emit(op_st, 5'd11, 5'd10, 5'd0, 12'h008);
        emit(op_ld, 5'd12, 5'd10, 5'd0, 12'h008);
        emit(op_addi, 5'd0, 5'd11, 5'd0, 12'h003);
        emit(op_add, 5'd13, 5'd0, 5'd12, 12'h000);
    endtask

    task automatic build_undecoded();
        n_instr = 0;
        emit(op_addi, 5'd1, 5'd0, 5'd0, 12'h009);
        emit_raw(32'h00000000);
        emit(op_addi, 5'd2, 5'd0, 5'd0, 12'h004);
        emit_raw(32'hdeadbeef);
        emit(op_add, 5'd3, 5'd1, 5'd2, 12'h000);
        emit_raw(32'hffffffff);
    endtask

    task automatic test_independent();
        build_independent();
        run_program("independent", 1'b0, 1'b1);
    endtask

    task automatic test_chain();
        build_chain();
        run_program("chain", 1'b0, 1'b0);
    endtask

    task automatic test_store_load();
        build_mem();
        run_program("store_load", 1'b0, 1'b0);
        check_word("store_load dmem", 32'h000005a5, i_dmem.mem[8'h12]);
    endtask

    task automatic test_undecoded();
        build_undecoded();
        run_program("undecoded", 1'b0, 1'b0);
    endtask

    task automatic test_wait_states();
        build_independent();
        run_program("wait independent", 1'b1, 1'b0);
        build_chain();
        run_program("wait chain", 1'b1, 1'b0);
        build_mem();
        run_program("wait store_load", 1'b1, 1'b0);
        check_word("wait store_load dmem", 32'h000005a5, i_dmem.mem[8'h12]);
        build_undecoded();
        run_program("wait undecoded", 1'b1, 1'b0);
    endtask

    initial begin
        aclk = 1'b0;
        rst_n = 1'b0;
        wait_en = 1'b0;
        cycle_count = 0;
        word_errs = 0;
        reg_errs = 0;
        valid_errs = 0;
        n_checks = 0;
        n_instr = 0;
        test_independent();
        test_chain();
        test_store_load();
        test_undecoded();
        test_wait_states();
        $display("checks %0d, word errors %0d, reg errors %0d, valid errors %0d",
                 n_checks, word_errs, reg_errs, valid_errs);
        if (word_errs + reg_errs + valid_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_stage.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/exec_unit.sv
hw/writeback_unit.sv
hw/cpu_core.sv
verification/sram_model.sv
verification/cpu_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cpu_core_tb -o cpu_core_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/cpu_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
